//--- logic/lc_pkg.sv
/*
  Shared constants and types for the life-cycle controller stand-in.
  Magic addresses assume a 32-bit AXI address map.
  lc_tx_t codes other than on and off are treated as off everywhere.
*/

`default_nettype none

package lc_pkg;

    // --------------------------------------------------
    // AXI address map
    // --------------------------------------------------
    localparam int unsigned lc_addr_width = 32;

    typedef logic [lc_addr_width-1:0] lc_addr_t;

    // Read here starts the delayed power and reset sequence
    localparam lc_addr_t lc_rst_addr = 32'h7000_0444;
    // Read here flips the RMA / SCRAP strap level
    localparam lc_addr_t lc_strap_addr = 32'h7000_0448;

    // --------------------------------------------------
    // Life-cycle transport encoding
    // --------------------------------------------------
    localparam int unsigned lc_tx_width = 4;

    typedef logic [lc_tx_width-1:0] lc_tx_t;

    // Multi-bit on/off codes, complementary on purpose
    localparam lc_tx_t lc_tx_on  = 4'b0101;
    localparam lc_tx_t lc_tx_off = 4'b1010;

    // --------------------------------------------------
    // Reset sequence timing
    // --------------------------------------------------
    // Stages in the trigger delay line
    localparam int unsigned lc_trig_delay = 20;

    // Power counter
    localparam int unsigned lc_cnt_width = 10;

    typedef logic [lc_cnt_width-1:0] lc_cnt_t;

    // Power-up length, also sets the reset-low window
    localparam lc_cnt_t lc_power_cycles = lc_cnt_t'(500);

endpackage

`default_nettype wire

//--- logic/lc_axi_snoop.sv
/*
  Passive observer of the AXI read-address channel.
  Never drives arready; a beat counts only when arvalid and arready are high.
  rst_trig is a one-cycle strobe; back-to-back reset hits give every other strobe.
*/

`timescale 1ns/1ps
`default_nettype none

module lc_axi_snoop (
    input  wire logic          clk,
    input  wire logic          reset_n,
    input  wire logic          arvalid,
    input  wire logic          arready,
    input  wire lc_pkg::lc_addr_t araddr,
    output logic               rst_trig,
    output logic               allow_rma_scrap
);

    // --------------------------------------------------
    // Beat decode
    // --------------------------------------------------
    logic ar_accept;
    logic rst_hit;
    logic strap_hit;

    // Address handshake completes this edge
    assign ar_accept = arvalid && arready;

    // Compare against the two magic locations
    assign rst_hit   = ar_accept && (araddr == lc_pkg::lc_rst_addr);
    assign strap_hit = ar_accept && (araddr == lc_pkg::lc_strap_addr);

    // --------------------------------------------------
    // Reset trigger strobe
    // --------------------------------------------------
    // High for one cycle after a reset hit
    // A hit while the strobe is up is dropped, so no stretching
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rst_trig <= 1'b0;
        end else begin
            rst_trig <= rst_hit && !rst_trig;
        end
    end

    // --------------------------------------------------
    // RMA / SCRAP strap level
    // --------------------------------------------------
    // Flips on each strap hit
    // Masked in the strobe cycle so a reset request wins
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            allow_rma_scrap <= 1'b0;
        end else if (strap_hit && !rst_trig) begin
            allow_rma_scrap <= !allow_rma_scrap;
        end
    end

endmodule

`default_nettype wire

//--- logic/lc_rst_seq.sv
/*
  Delayed fake reset generator.
  fake_reset is high out of reset, falls 22 cycles after a rst_trig strobe,
  then stays low for lc_power_cycles + 1 cycles.
  Triggers that arrive while the power counter runs are dropped.
*/

`timescale 1ns/1ps
`default_nettype none

module lc_rst_seq (
    input  wire logic clk,
    input  wire logic reset_n,
    input  wire logic rst_trig,
    output logic      fake_reset
);

    // --------------------------------------------------
    // Trigger delay line
    // --------------------------------------------------
    logic [lc_pkg::lc_trig_delay-1:0] trig_dly;
    // Extra flop after the last stage
    logic                             trig_late;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            trig_dly  <= '0;
            trig_late <= 1'b0;
        end else begin
            // Shift toward the MSB, newest strobe enters at bit 0
            trig_dly  <= {trig_dly[lc_pkg::lc_trig_delay-2:0], rst_trig};
            trig_late <= trig_dly[lc_pkg::lc_trig_delay-1];
        end
    end

    // --------------------------------------------------
    // Power counter and fake reset
    // --------------------------------------------------
    lc_pkg::lc_cnt_t power_cnt;
    logic            cnt_busy;

    // Counter still running, sequence not yet settled
    assign cnt_busy = power_cnt < lc_pkg::lc_power_cycles;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            power_cnt  <= '0;
            // Part held in reset during power-up
            fake_reset <= 1'b1;
        end else if (cnt_busy) begin
            // Hold output level, ignore any delayed trigger
            power_cnt  <= power_cnt + lc_pkg::lc_cnt_t'(1);
            fake_reset <= fake_reset;
        end else if (trig_late) begin
            // Start a new low window
            power_cnt  <= '0;
            fake_reset <= 1'b0;
        end else begin
            // Counter parked at the end, release reset
            power_cnt  <= power_cnt;
            fake_reset <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/lc_clk_byp_resp.sv
/*
  Clock-bypass acknowledge responder for the clock manager.
  Only the exact lc_tx_on code counts as a request.
  A held request gives a one-cycle on / one-cycle off pulse train.
*/

`timescale 1ns/1ps
`default_nettype none

module lc_clk_byp_resp (
    input  wire logic           clk,
    input  wire logic           reset_n,
    input  wire lc_pkg::lc_tx_t clk_byp_req,
    output lc_pkg::lc_tx_t      clk_byp_ack
);

    logic req_on;
    logic ack_was_off;

    // Strict decode, invalid codes read as off
    assign req_on = (clk_byp_req == lc_pkg::lc_tx_on);

    // Previous ack, only the two valid codes are ever stored
    assign ack_was_off = (clk_byp_ack == lc_pkg::lc_tx_off);

    // --------------------------------------------------
    // Acknowledge register
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            clk_byp_ack <= lc_pkg::lc_tx_off;
        end else if (req_on && ack_was_off) begin
            clk_byp_ack <= lc_pkg::lc_tx_on;
        end else begin
            // Drops back after one on cycle
            clk_byp_ack <= lc_pkg::lc_tx_off;
        end
    end

endmodule

`default_nettype wire

//--- logic/lc_bfm_top.sv
/*
  Life-cycle controller stand-in for chip-level simulation.
  AXI read-address signals are observed only; no read data is returned.
  No OTP, token or escalation logic is modelled.
*/

`timescale 1ns/1ps
`default_nettype none

module lc_bfm_top (
    input  wire logic             clk,
    input  wire logic             reset_n,
    // AXI read-address channel, copied from the port
    input  wire logic             arvalid,
    input  wire logic             arready,
    input  wire lc_pkg::lc_addr_t araddr,
    // Clock manager request
    input  wire lc_pkg::lc_tx_t   clk_byp_req,
    output logic                  fake_reset,
    output logic                  allow_rma_scrap,
    output lc_pkg::lc_tx_t        clk_byp_ack
);

    // One-cycle strobe from the snooper into the sequencer
    logic rst_trig;

    // --------------------------------------------------
    // AXI snooper
    // --------------------------------------------------
    lc_axi_snoop u_axi_snoop (
        .clk             (clk),
        .reset_n         (reset_n),
        .arvalid         (arvalid),
        .arready         (arready),
        .araddr          (araddr),
        .rst_trig        (rst_trig),
        .allow_rma_scrap (allow_rma_scrap)
    );

    // --------------------------------------------------
    // Power and reset sequencer
    // --------------------------------------------------
    lc_rst_seq u_rst_seq (
        .clk        (clk),
        .reset_n    (reset_n),
        .rst_trig   (rst_trig),
        .fake_reset (fake_reset)
    );

    // --------------------------------------------------
    // Clock bypass responder, independent of the rest
    // --------------------------------------------------
    lc_clk_byp_resp u_clk_byp_resp (
        .clk         (clk),
        .reset_n     (reset_n),
        .clk_byp_req (clk_byp_req),
        .clk_byp_ack (clk_byp_ack)
    );

endmodule

`default_nettype wire

//--- sim/lc_bfm_chk.sv
/*
  Port-level assertions for lc_bfm_top, attached with bind.
  Low window length is measured with a local run counter.
*/

`timescale 1ns/1ps
`default_nettype none

module lc_bfm_chk (
    input wire logic           clk,
    input wire logic           reset_n,
    input wire logic           fake_reset,
    input wire lc_pkg::lc_tx_t clk_byp_ack
);

    // Consecutive low cycles of fake_reset
    int unsigned low_run;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            low_run <= '0;
        end else if (fake_reset) begin
            low_run <= '0;
        end else begin
            low_run <= low_run + 32'd1;
        end
    end

    // --------------------------------------------------
    // Clock bypass acknowledge
    // --------------------------------------------------
    a_ack_valid: assert property (@(posedge clk) disable iff (!reset_n)
        (clk_byp_ack == lc_pkg::lc_tx_on) || (clk_byp_ack == lc_pkg::lc_tx_off))
        else $error("clk_byp_ack holds a code outside on and off");

    a_ack_single: assert property (@(posedge clk) disable iff (!reset_n)
        (clk_byp_ack == lc_pkg::lc_tx_on) |=> (clk_byp_ack != lc_pkg::lc_tx_on))
        else $error("clk_byp_ack stayed on for two cycles");

    // --------------------------------------------------
    // Fake reset low window
    // --------------------------------------------------
    // Checked at the rise, run counter covers the whole window
    a_low_window: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(fake_reset) |-> (low_run >= 32'(lc_pkg::lc_power_cycles)))
        else $error("fake_reset low window shorter than the power count");

endmodule

bind lc_bfm_top lc_bfm_chk u_chk (
    .clk         (clk),
    .reset_n     (reset_n),
    .fake_reset  (fake_reset),
    .clk_byp_ack (clk_byp_ack)
);

`default_nettype wire

//--- sim/lc_bfm_tb.sv
/*
  Testbench for the life-cycle controller stand-in.
  Walks power-up, a table of AXI read beats and the clock-bypass handshake.
  Expected strap and acknowledge values come from small reference models.
*/

`timescale 1ns/1ps
`default_nettype none

module lc_bfm_tb;

    // --------------------------------------------------
    // Test constants
    // --------------------------------------------------
    localparam int power_cycles = int'(lc_pkg::lc_power_cycles);
    // Allowed window for the fall after a reset read
    localparam int fall_min     = 20;
    localparam int fall_max     = 26;
    localparam int low_slack    = 5;
    // Quiet cycles watched when no low window is due
    localparam int watch_cycles = 30;
    localparam int stim_count   = 16;
    // Marker for a random non-magic address
    localparam lc_pkg::lc_addr_t rnd_addr = '0;

    // One table row, low means a fake_reset window once the group ends
    typedef struct packed {
        lc_pkg::lc_addr_t addr;
        logic             rdy;
        logic             b2b;
        logic             strap;
        logic             low;
    } stim_t;

    logic             clk = 1'b0;
    logic             reset_n;
    logic             arvalid;
    logic             arready;
    lc_pkg::lc_addr_t araddr;
    lc_pkg::lc_tx_t   clk_byp_req;
    logic             fake_reset;
    logic             allow_rma_scrap;
    lc_pkg::lc_tx_t   clk_byp_ack;

    int   errors   = 0;
    int   timeouts = 0;
    // Reference model state
    logic model_trig;
    logic model_strap;
    logic model_ack_on;

    // b2b rows are accepted on the edge right after the row before
    stim_t stim_tbl [stim_count] = '{
        // addr                  rdy   b2b   strap low
        '{rnd_addr,              1'b1, 1'b0, 1'b0, 1'b0},
        '{lc_pkg::lc_strap_addr, 1'b1, 1'b0, 1'b1, 1'b0},
        '{lc_pkg::lc_strap_addr, 1'b0, 1'b0, 1'b1, 1'b0},
        '{rnd_addr,              1'b1, 1'b0, 1'b1, 1'b0},
        '{lc_pkg::lc_strap_addr, 1'b1, 1'b0, 1'b0, 1'b0},
        '{lc_pkg::lc_strap_addr, 1'b1, 1'b0, 1'b1, 1'b0},
        '{lc_pkg::lc_rst_addr,   1'b0, 1'b0, 1'b1, 1'b0},
        '{lc_pkg::lc_rst_addr,   1'b1, 1'b0, 1'b1, 1'b1},
        // Strap hit masked by the strobe
        '{lc_pkg::lc_rst_addr,   1'b1, 1'b0, 1'b1, 1'b1},
        '{lc_pkg::lc_strap_addr, 1'b1, 1'b1, 1'b1, 1'b1},
        '{lc_pkg::lc_strap_addr, 1'b1, 1'b0, 1'b0, 1'b0},
        // Second reset hit dropped, so the strap hit after it counts
        '{lc_pkg::lc_rst_addr,   1'b1, 1'b0, 1'b0, 1'b1},
        '{lc_pkg::lc_rst_addr,   1'b1, 1'b1, 1'b0, 1'b1},
        '{lc_pkg::lc_strap_addr, 1'b1, 1'b1, 1'b1, 1'b1},
        '{rnd_addr,              1'b1, 1'b0, 1'b1, 1'b0},
        '{lc_pkg::lc_strap_addr, 1'b1, 1'b0, 1'b0, 1'b0}
    };

    lc_bfm_top u_dut (
        .clk             (clk),
        .reset_n         (reset_n),
        .arvalid         (arvalid),
        .arready         (arready),
        .araddr          (araddr),
        .clk_byp_req     (clk_byp_req),
        .fake_reset      (fake_reset),
        .allow_rma_scrap (allow_rma_scrap),
        .clk_byp_ack     (clk_byp_ack)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s actual=0x%0h expected=0x%0h",
                     $time, name, actual, expected);
            errors++;
        end
    endtask

    // Never returns either magic address
    function automatic lc_pkg::lc_addr_t random_addr();
        lc_pkg::lc_addr_t a;
        a = $urandom;
        if (a == lc_pkg::lc_rst_addr || a == lc_pkg::lc_strap_addr) begin
            a = a ^ 32'h1000_0000;
        end
        return a;
    endfunction

    // Callers sit on a rising edge
    task automatic set_beat(input lc_pkg::lc_addr_t addr, input logic rdy);
        arvalid <= 1'b1;
        arready <= rdy;
        araddr  <= addr;
    endtask

    // arready toggles freely, no beat without arvalid
    task automatic set_idle();
        arvalid <= 1'b0;
        arready <= 1'($urandom % 2);
        araddr  <= $urandom;
    endtask

    // Strobe masks itself and the strap flip
    task automatic model_accept(input lc_pkg::lc_addr_t addr, input logic rdy);
        logic rst_hit;
        logic strap_hit;
        rst_hit   = rdy && (addr == lc_pkg::lc_rst_addr);
        strap_hit = rdy && (addr == lc_pkg::lc_strap_addr);
        if (strap_hit && !model_trig) begin
            model_strap = !model_strap;
        end
        model_trig = rst_hit && !model_trig;
    endtask

    // Entered one negedge after the accepting edge
    task automatic check_low_window();
        int   cycles;
        int   low_cnt;
        logic done;
        cycles = 1;
        while (fake_reset === 1'b1 && cycles < fall_max) begin
            @(negedge clk);
            cycles++;
        end
        if (fake_reset === 1'b1) begin
            $display("Timeout at t=%0t: fake_reset did not fall within %0d cycles of the reset read",
                     $time, fall_max);
            timeouts++;
        end else begin
            check_val($sformatf("fake_reset fall delay %0d cycles in %0d..%0d",
                                cycles, fall_min, fall_max),
                      32'(cycles >= fall_min), 32'd1);
            low_cnt = 1;
            done    = 1'b0;
            while (!done && low_cnt <= power_cycles + low_slack) begin
                @(negedge clk);
                if (fake_reset === 1'b1) begin
                    done = 1'b1;
                end else begin
                    low_cnt++;
                end
            end
            if (!done) begin
                $display("Timeout at t=%0t: fake_reset stayed low past %0d cycles",
                         $time, power_cycles + low_slack);
                timeouts++;
            end else begin
                check_val($sformatf("fake_reset low window %0d cycles >= %0d",
                                    low_cnt, power_cycles),
                          32'(low_cnt >= power_cycles), 32'd1);
            end
        end
    endtask

    // First drop reported only
    task automatic watch_high(input int n);
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            if (fake_reset !== 1'b1) begin
                check_val("fake_reset", 32'(fake_reset), 32'd1);
                break;
            end
        end
    endtask

    // Edge samples the request already on the port, then a new one is set
    task automatic run_byp(input lc_pkg::lc_tx_t code, input int n);
        repeat (n) begin
            @(posedge clk);
            model_ack_on = (clk_byp_req == lc_pkg::lc_tx_on) && !model_ack_on;
            clk_byp_req <= code;
            @(negedge clk);
            check_val("clk_byp_ack", 32'(clk_byp_ack),
                      model_ack_on ? 32'(lc_pkg::lc_tx_on) : 32'(lc_pkg::lc_tx_off));
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int unsigned      seed_draw;
        int               gap;
        int               i;
        lc_pkg::lc_addr_t addr;
        stim_t            e;
        logic             group_end;
        lc_pkg::lc_tx_t   bad_code;

        seed_draw = $urandom(62505);
        reset_n     <= 1'b0;
        arvalid     <= 1'b0;
        arready     <= 1'b0;
        araddr      <= '0;
        clk_byp_req <= lc_pkg::lc_tx_off;
        model_trig   = 1'b0;
        model_strap  = 1'b0;
        model_ack_on = 1'b0;

        repeat (5) @(posedge clk);
        reset_n <= 1'b1;

        // Power-up, with a reset read that must be swallowed
        @(negedge clk);
        check_val("fake_reset", 32'(fake_reset), 32'd1);
        check_val("allow_rma_scrap", 32'(allow_rma_scrap), 32'd0);
        check_val("clk_byp_ack", 32'(clk_byp_ack), 32'(lc_pkg::lc_tx_off));
        for (i = 0; i < power_cycles + 40; i++) begin
            @(posedge clk);
            if (i == 10) begin
                set_beat(lc_pkg::lc_rst_addr, 1'b1);
                model_accept(lc_pkg::lc_rst_addr, 1'b1);
            end else if (i == 11) begin
                set_idle();
            end
            @(negedge clk);
            if (fake_reset !== 1'b1) begin
                check_val("fake_reset", 32'(fake_reset), 32'd1);
                break;
            end
        end

        // Beat table
        for (i = 0; i < stim_count; i++) begin
            e = stim_tbl[i];
            if (!e.b2b) begin
                gap = $urandom_range(4, 1);
                repeat (gap) begin
                    @(posedge clk);
                    set_idle();
                end
                model_trig = 1'b0;
            end
            addr = (e.addr == rnd_addr) ? random_addr() : e.addr;
            @(posedge clk);
            set_beat(addr, e.rdy);
            model_accept(addr, e.rdy);
            if (i == stim_count - 1) begin
                group_end = 1'b1;
            end else begin
                group_end = !stim_tbl[i + 1].b2b;
            end
            if (group_end) begin
                // Accepting edge of the last beat
                @(posedge clk);
                set_idle();
                @(negedge clk);
                check_val("allow_rma_scrap", 32'(allow_rma_scrap), 32'(e.strap));
                check_val("allow_rma_scrap", 32'(allow_rma_scrap), 32'(model_strap));
                if (e.low) begin
                    check_low_window();
                end else begin
                    watch_high(watch_cycles);
                end
            end
        end

        // Clock bypass handshake
        run_byp(lc_pkg::lc_tx_on, 8);
        run_byp(lc_pkg::lc_tx_off, 3);
        for (i = 0; i < 6; i++) begin
            bad_code = 4'($urandom);
            if (bad_code == lc_pkg::lc_tx_on) begin
                bad_code = 4'b0000;
            end
            run_byp(bad_code, 1);
        end
        run_byp(lc_pkg::lc_tx_on, 5);
        run_byp(4'b1111, 3);

        $display("lc_bfm_tb done: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lc_bfm.f
logic/lc_pkg.sv
logic/lc_axi_snoop.sv
logic/lc_rst_seq.sv
logic/lc_clk_byp_resp.sv
logic/lc_bfm_top.sv
sim/lc_bfm_chk.sv
sim/lc_bfm_tb.sv

//--- Makefile
# Verilator flow for the life-cycle controller stand-in

TOOL       = verilator
TOP        = lc_bfm_tb
FILELIST   = lc_bfm.f
OBJ_DIR    = obj_dir
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
PASS_MSG   = >>> PASS

.PHONY: all build run lint clean

all: run

# Compile testbench and RTL into one executable
build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status follows the pass line in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
